//--- hdl/hist_bin_accumulate.sv
`timescale 1ns/1ps

module hist_bin_accumulate
    import hist_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       res,
    input  logic       ev_valid,
    input  hist_addr_t ev_addr,
    input  logic       frame_last,
    output logic       his_num,
    output logic       bank_swap,
    input  logic       rd_en,
    input  hist_addr_t rd_addr,
    output bin_count_t rd_data
);

    // two banks, his_num picks the one being filled
    bin_count_t bank_mem [2][HIST_DEPTH];

    // frame end, one cycle late
    logic frame_last_d;

    // bank for the event now being read
    logic act_bank;
    // bank owned by the readout
    logic rd_bank;

    // pending write stage
    logic       pend_valid;
    hist_addr_t pend_addr;
    logic       pend_bank;
    bin_count_t pend_val;

    // read stage
    logic       fwd_hit;
    bin_count_t cur_val;
    bin_count_t inc_val;

    // events after frame_last already belong to the next bank,
    // his_num itself only flips one cycle later
    assign act_bank = his_num ^ frame_last_d;
    assign rd_bank  = ~his_num;

    // pending write to the same entry is newer than the array
    assign fwd_hit = pend_valid && (pend_addr == ev_addr) && (pend_bank == act_bank);

    always_comb begin
        if (fwd_hit) begin
            cur_val = pend_val;
        end else begin
            cur_val = bank_mem[act_bank][ev_addr];
        end
    end

    // saturating increment
    assign inc_val = (cur_val == bin_count_t'(COUNT_MAX)) ? cur_val : cur_val + 1'b1;

    // read stage to write stage
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            pend_valid <= 1'b0;
        end else begin
            pend_valid <= ev_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ev_valid) begin
            pend_addr <= ev_addr;
            pend_bank <= act_bank;
            pend_val  <= inc_val;
        end
    end

    // bank array, accumulate write plus clear behind the readout
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < HIST_DEPTH; i++) begin
                    bank_mem[b][i] <= '0;
                end
            end
        end else begin
            if (pend_valid) begin
                bank_mem[pend_bank][pend_addr] <= pend_val;
            end
            // read clears the entry so the bank comes back empty
            if (rd_en) begin
                bank_mem[rd_bank][rd_addr] <= '0;
            end
        end
    end

    // readout data, one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= bank_mem[rd_bank][rd_addr];
        end
    end

    // bank swap two cycles after frame_last,
    // last write of the old frame has landed by then
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            frame_last_d <= 1'b0;
            his_num      <= 1'b0;
            bank_swap    <= 1'b0;
        end else begin
            frame_last_d <= frame_last;
            bank_swap    <= frame_last_d;
            if (frame_last_d) begin
                his_num <= ~his_num;
            end
        end
    end

endmodule

//--- hdl/hist_builder_top.sv
`timescale 1ns/1ps

module hist_builder_top
    import hist_cfg_pkg::*;
#(
    parameter int DATA_NUM  = 8,
    parameter int PIXEL_NUM = 8,
    parameter int ACQ_NUM   = 40
)
(
    input  logic       clk,
    input  logic       res,
    input  logic       wr_en,
    input  bin_addr_t  addr,
    output logic       hist_valid,
    output pixel_idx_t hist_pixel,
    output bin_addr_t  hist_bin,
    output bin_count_t hist_count,
    output logic       his_num,
    output logic       ro_busy,
    output logic       ro_overrun
);

    // sequencer to accumulator
    logic       ev_valid;
    hist_addr_t ev_addr;
    logic       frame_last;

    // accumulator and readout
    logic       bank_swap;
    logic       rd_en;
    hist_addr_t rd_addr;
    bin_count_t rd_data;

    // sequence stage, nested event counting
    hist_sequencer #(
        .DATA_NUM  (DATA_NUM),
        .PIXEL_NUM (PIXEL_NUM),
        .ACQ_NUM   (ACQ_NUM)
    ) hist_sequencer_i (
        .clk        (clk),
        .res        (res),
        .wr_en      (wr_en),
        .addr       (addr),
        .ev_valid   (ev_valid),
        .ev_addr    (ev_addr),
        .frame_last (frame_last)
    );

    // accumulate stage, banks and swap
    hist_bin_accumulate hist_bin_accumulate_i (
        .clk        (clk),
        .res        (res),
        .ev_valid   (ev_valid),
        .ev_addr    (ev_addr),
        .frame_last (frame_last),
        .his_num    (his_num),
        .bank_swap  (bank_swap),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

    // readout stage, scan of the finished bank
    hist_readout hist_readout_i (
        .clk        (clk),
        .res        (res),
        .bank_swap  (bank_swap),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .hist_valid (hist_valid),
        .hist_pixel (hist_pixel),
        .hist_bin   (hist_bin),
        .hist_count (hist_count),
        .ro_busy    (ro_busy),
        .ro_overrun (ro_overrun)
    );

endmodule

//--- hdl/hist_cfg_pkg.sv
package hist_cfg_pkg;

    // field widths
    localparam int BIN_W       = 6;
    localparam int PIXEL_W     = 3;
    localparam int HIST_ADDR_W = PIXEL_W + BIN_W;
    localparam int COUNT_W     = 8;

    // array geometry
    localparam int BIN_NUM    = 64;
    localparam int PIXEL_MAX  = 8;
    // one entry per pixel and bin
    localparam int HIST_DEPTH = PIXEL_MAX * BIN_NUM;

    // saturation value of one bin
    localparam int COUNT_MAX = 255;

    // time bin of one event
    typedef logic [BIN_W-1:0] bin_addr_t;

    // pixel number
    typedef logic [PIXEL_W-1:0] pixel_idx_t;

    // bank address, pixel in the upper bits, bin in the lower bits
    typedef logic [HIST_ADDR_W-1:0] hist_addr_t;

    // one bin count
    typedef logic [COUNT_W-1:0] bin_count_t;

endpackage

//--- hdl/hist_readout.sv
`timescale 1ns/1ps

module hist_readout
    import hist_cfg_pkg::*;
    import hist_state_pkg::*;
(
    input  logic       clk,
    input  logic       res,
    input  logic       bank_swap,
    output logic       rd_en,
    output hist_addr_t rd_addr,
    input  bin_count_t rd_data,
    output logic       hist_valid,
    output pixel_idx_t hist_pixel,
    output bin_addr_t  hist_bin,
    output bin_count_t hist_count,
    output logic       ro_busy,
    output logic       ro_overrun
);

    ro_state_t  state;
    hist_addr_t scan_addr;
    // address of the read now returning
    hist_addr_t out_addr;
    logic       scan_end;

    assign scan_end = (scan_addr == hist_addr_t'(HIST_DEPTH - 1));

    // one read per scan cycle
    assign rd_en   = (state == ro_scan);
    assign rd_addr = scan_addr;

    // busy until the drain cycle has shown the last bin
    assign ro_busy = (state != ro_idle);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= ro_idle;
            scan_addr  <= '0;
            ro_overrun <= 1'b0;
        end else if (bank_swap) begin
            // swap during a scan, previous frame was too short
            if (state != ro_idle) begin
                ro_overrun <= 1'b1;
            end
            state     <= ro_scan;
            scan_addr <= '0;
        end else begin
            case (state)
                ro_scan: begin
                    scan_addr <= scan_addr + 1'b1;
                    if (scan_end) begin
                        state <= ro_drain;
                    end
                end
                ro_drain: begin
                    state <= ro_idle;
                end
                default: begin
                    state <= ro_idle;
                end
            endcase
        end
    end

    // output strobe follows the read by one cycle
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            hist_valid <= 1'b0;
        end else begin
            hist_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        out_addr <= rd_addr;
    end

    // pixel major split of the delayed address
    assign hist_pixel = out_addr[HIST_ADDR_W-1 -: PIXEL_W];
    assign hist_bin   = out_addr[BIN_W-1:0];
    assign hist_count = rd_data;

endmodule

//--- hdl/hist_sequencer.sv
`timescale 1ns/1ps

module hist_sequencer
    import hist_cfg_pkg::*;
#(
    parameter int DATA_NUM  = 8,
    parameter int PIXEL_NUM = 8,
    parameter int ACQ_NUM   = 40
)
(
    input  logic       clk,
    input  logic       res,
    input  logic       wr_en,
    input  bin_addr_t  addr,
    output logic       ev_valid,
    output hist_addr_t ev_addr,
    output logic       frame_last
);

    // counter widths, wide enough for the terminal value
    localparam int IN_W  = $clog2(DATA_NUM + 1);
    localparam int ACQ_W = $clog2(ACQ_NUM + 1);

    // pixel count limited to what the bank holds
    localparam int PIXEL_LIM = (PIXEL_NUM > PIXEL_MAX) ? PIXEL_MAX : PIXEL_NUM;

    logic [IN_W-1:0]  input_cnt;
    pixel_idx_t       pixel_cnt;
    logic [ACQ_W-1:0] acq_cnt;

    // terminal count flags
    logic input_last;
    logic pixel_last;
    logic acq_last;
    logic ev_last;

    assign input_last = (input_cnt == IN_W'(DATA_NUM - 1));
    assign pixel_last = (pixel_cnt == pixel_idx_t'(PIXEL_LIM - 1));
    assign acq_last   = (acq_cnt == ACQ_W'(ACQ_NUM - 1));

    // last event of the frame, all three counters at their end
    assign ev_last = input_last && pixel_last && acq_last;

    // nested counters, each moves only when the one below wraps
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            input_cnt <= '0;
            pixel_cnt <= '0;
            acq_cnt   <= '0;
        end else if (wr_en) begin
            // events per pixel
            if (input_last) begin
                input_cnt <= '0;
            end else begin
                input_cnt <= input_cnt + 1'b1;
            end

            // pixels per acquisition
            if (input_last) begin
                if (pixel_last) begin
                    pixel_cnt <= '0;
                end else begin
                    pixel_cnt <= pixel_cnt + 1'b1;
                end
            end

            // acquisitions per frame, wraps with the frame
            if (input_last && pixel_last) begin
                if (acq_last) begin
                    acq_cnt <= '0;
                end else begin
                    acq_cnt <= acq_cnt + 1'b1;
                end
            end
        end
    end

    // event strobe and frame end flag
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            ev_valid   <= 1'b0;
            frame_last <= 1'b0;
        end else begin
            ev_valid   <= wr_en;
            frame_last <= wr_en && ev_last;
        end
    end

    // full bank address, current pixel on top of the bin
    always_ff @(posedge clk) begin
        if (wr_en) begin
            ev_addr <= {pixel_cnt, addr};
        end
    end

endmodule

//--- hdl/hist_state_pkg.sv
package hist_state_pkg;

    // readout fsm
    // ro_idle   waiting for a bank swap
    // ro_scan   one read per cycle through the bank
    // ro_drain  last read data still on its way back
    typedef enum logic [1:0] {
        ro_idle  = 2'd0,
        ro_scan  = 2'd1,
        ro_drain = 2'd2
    } ro_state_t;

endpackage

//--- hist_builder.f
hdl/hist_cfg_pkg.sv
hdl/hist_state_pkg.sv
hdl/hist_sequencer.sv
hdl/hist_bin_accumulate.sv
hdl/hist_readout.sv
hdl/hist_builder_top.sv
verif/hist_builder_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the histogram builder testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=hist_builder_tb
build_dir=obj_dir
sim_bin="sim_${top}"

verilator --binary --timing --assert -Wno-fatal \
    --top-module "$top" -f hist_builder.f \
    --Mdir "$build_dir" -o "$sim_bin"
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

sim_out=$("./${build_dir}/${sim_bin}")
status=$?
echo "$sim_out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# pass only if the testbench printed its pass line
if echo "$sim_out" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1

//--- verif/hist_builder_tb.sv
`timescale 1ns/1ps

module hist_builder_tb
    import hist_cfg_pkg::*;
();

    // frame geometry of the main DUT
    localparam int DATA_NUM     = 8;
    localparam int PIXEL_NUM    = 8;
    localparam int ACQ_NUM      = 40;
    localparam int FRAME_EVENTS = DATA_NUM * PIXEL_NUM * ACQ_NUM;
    // second DUT, frame far shorter than one readout
    localparam int SHORT_ACQ    = 1;
    localparam int SHORT_EVENTS = DATA_NUM * PIXEL_NUM * SHORT_ACQ;
    // wait limits in cycles
    localparam int SWAP_TIMEOUT = 20;
    localparam int SCAN_TIMEOUT = 1000;
    // bin hit by every event of the saturation frame
    localparam int SAT_BIN      = 37;

    logic       clk;
    logic       res;
    logic       wr_en;
    bin_addr_t  addr;
    logic       hist_valid;
    pixel_idx_t hist_pixel;
    bin_addr_t  hist_bin;
    bin_count_t hist_count;
    logic       his_num;
    logic       ro_busy;
    logic       ro_overrun;

    // short frame DUT
    logic       short_wr_en;
    bin_addr_t  short_addr;
    logic       short_valid;
    pixel_idx_t short_pixel;
    bin_addr_t  short_bin;
    bin_count_t short_count;
    logic       short_his_num;
    logic       short_busy;
    logic       short_overrun;

    logic [31:0] rng_state = 32'hdbefd99f;
    // running counts of the frame being sent, frozen copy for the readout
    int model_cnt [HIST_DEPTH];
    int snap_cnt  [HIST_DEPTH];
    // last count the DUT reported per entry
    int seen_cnt  [HIST_DEPTH];
    int scan_pos;
    int valid_seen;
    int error_cnt;
    int tests_run;
    int tests_failed;
    bit ro_expected;
    bit timed_out;

    hist_builder_top #(
        .DATA_NUM  (DATA_NUM),
        .PIXEL_NUM (PIXEL_NUM),
        .ACQ_NUM   (ACQ_NUM)
    ) hist_builder_top_i (
        .clk        (clk),
        .res        (res),
        .wr_en      (wr_en),
        .addr       (addr),
        .hist_valid (hist_valid),
        .hist_pixel (hist_pixel),
        .hist_bin   (hist_bin),
        .hist_count (hist_count),
        .his_num    (his_num),
        .ro_busy    (ro_busy),
        .ro_overrun (ro_overrun)
    );

    // one acquisition per frame, overruns its own readout
    hist_builder_top #(
        .DATA_NUM  (DATA_NUM),
        .PIXEL_NUM (PIXEL_NUM),
        .ACQ_NUM   (SHORT_ACQ)
    ) short_frame_i (
        .clk        (clk),
        .res        (res),
        .wr_en      (short_wr_en),
        .addr       (short_addr),
        .hist_valid (short_valid),
        .hist_pixel (short_pixel),
        .hist_bin   (short_bin),
        .hist_count (short_count),
        .his_num    (short_his_num),
        .ro_busy    (short_busy),
        .ro_overrun (short_overrun)
    );

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    // xorshift32
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic string test_name(input int t);
        case (t)
            1: return "reset state";
            2: return "random bins with idle gaps";
            3: return "back to back frame, 512 bins and bank toggle";
            4: return "single bin saturation";
            5: return "reused bank cleared on read";
            default: return "overrun on short frame";
        endcase
    endfunction

    task automatic compare_value(input string sig, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
        assert (act_val === exp_val) else begin
            error_cnt++;
            $display("CHECK FAILED time %0t signal %s expected %0d actual %0d",
                     $time, sig, exp_val, act_val);
        end
    endtask

    // readout checker, samples away from the rising edge
    always @(negedge clk) begin
        if (res === 1'b1 && hist_valid === 1'b1) begin
            assert (ro_expected) else begin
                error_cnt++;
                $display("time %0t hist_valid seen while no frame had completed", $time);
            end
            if (ro_expected && scan_pos < HIST_DEPTH) begin
                // pixel major, ascending
                compare_value("hist_pixel", 32'(scan_pos / BIN_NUM), 32'(hist_pixel));
                compare_value("hist_bin", 32'(scan_pos % BIN_NUM), 32'(hist_bin));
                compare_value("hist_count", 32'(snap_cnt[scan_pos]), 32'(hist_count));
                seen_cnt[scan_pos] = int'(hist_count);
            end
            scan_pos++;
            valid_seen++;
        end
    end

    task automatic wait_busy(input logic level, input int limit, input string what);
        int cyc;
        cyc = 0;
        while (ro_busy !== level && cyc < limit && !timed_out) begin
            @(negedge clk);
            cyc++;
        end
        if (ro_busy !== level && !timed_out) begin
            timed_out = 1'b1;
            $display("time %0t gave up waiting for %s after %0d cycles", $time, what, cyc);
        end
    endtask

    task automatic wait_short_busy(input logic level, input int limit, input string what);
        int cyc;
        cyc = 0;
        while (short_busy !== level && cyc < limit && !timed_out) begin
            @(negedge clk);
            cyc++;
        end
        if (short_busy !== level && !timed_out) begin
            timed_out = 1'b1;
            $display("time %0t gave up waiting for %s after %0d cycles", $time, what, cyc);
        end
    endtask

    // one frame into the main DUT, model follows every accepted event
    task automatic run_frame(input bit use_gaps, input bit fixed_bin, input bin_addr_t bin_sel);
        logic [31:0] r;
        int          pix;
        int          idx;
        for (int ev = 0; ev < FRAME_EVENTS; ev++) begin
            r = next_rand();
            // idle cycles, addr keeps moving so a stray count would show
            if (use_gaps && r[12]) begin
                repeat (int'(r[9:8]) + 1) begin
                    @(posedge clk);
                    #1;
                    wr_en = 1'b0;
                    addr  = r[21:16];
                end
            end
            @(posedge clk);
            #1;
            wr_en = 1'b1;
            addr  = fixed_bin ? bin_sel : r[5:0];
            pix   = (ev / DATA_NUM) % PIXEL_NUM;
            idx   = pix * BIN_NUM + int'(addr);
            if (model_cnt[idx] < COUNT_MAX) begin
                model_cnt[idx]++;
            end
        end
        @(posedge clk);
        #1;
        wr_en = 1'b0;
        // frame done, freeze expected histogram
        for (int i = 0; i < HIST_DEPTH; i++) begin
            snap_cnt[i]  = model_cnt[i];
            model_cnt[i] = 0;
        end
        scan_pos    = 0;
        valid_seen  = 0;
        ro_expected = 1'b1;
    endtask

    task automatic check_readout(input logic prev_bank);
        logic exp_bank;
        exp_bank = ~prev_bank;
        wait_busy(1'b1, SWAP_TIMEOUT, "readout start");
        wait_busy(1'b0, SCAN_TIMEOUT, "readout end");
        ro_expected = 1'b0;
        compare_value("hist_valid count", 32'(HIST_DEPTH), 32'(valid_seen));
        compare_value("his_num", 32'(exp_bank), 32'(his_num));
        compare_value("ro_overrun", 32'd0, 32'(ro_overrun));
    endtask

    task automatic drive_short_frame();
        logic [31:0] r;
        for (int ev = 0; ev < SHORT_EVENTS; ev++) begin
            r = next_rand();
            @(posedge clk);
            #1;
            short_wr_en = 1'b1;
            short_addr  = r[5:0];
        end
        @(posedge clk);
        #1;
        short_wr_en = 1'b0;
    endtask

    task automatic run_test(input int t);
        logic prev_bank;
        int   cap;
        prev_bank = his_num;
        cap = (DATA_NUM * ACQ_NUM > COUNT_MAX) ? COUNT_MAX : DATA_NUM * ACQ_NUM;
        case (t)
            1: begin
                @(negedge clk);
                compare_value("hist_valid", 32'd0, 32'(hist_valid));
                compare_value("ro_busy", 32'd0, 32'(ro_busy));
                compare_value("ro_overrun", 32'd0, 32'(ro_overrun));
                compare_value("his_num", 32'd0, 32'(his_num));
                // checker flags any hist_valid while idle
                repeat (20) @(negedge clk);
            end
            2, 3, 5: begin
                run_frame(t != 3, 1'b0, '0);
                check_readout(prev_bank);
            end
            4: begin
                run_frame(1'b0, 1'b1, bin_addr_t'(SAT_BIN));
                check_readout(prev_bank);
                for (int p = 0; p < PIXEL_NUM; p++) begin
                    compare_value("saturated hist_count", 32'(cap),
                                  32'(seen_cnt[p * BIN_NUM + SAT_BIN]));
                end
            end
            default: begin
                drive_short_frame();
                wait_short_busy(1'b1, SWAP_TIMEOUT, "short frame readout start");
                // first swap finds the readout idle
                compare_value("short ro_overrun", 32'd0, 32'(short_overrun));
                // second frame lands while the first is still read out
                drive_short_frame();
                wait_short_busy(1'b0, SCAN_TIMEOUT, "short frame readout end");
                // still set after the restarted scan has ended
                compare_value("short ro_overrun", 32'd1, 32'(short_overrun));
                // two frames, two toggles
                compare_value("short his_num", 32'd0, 32'(short_his_num));
                compare_value("ro_overrun", 32'd0, 32'(ro_overrun));
            end
        endcase
    endtask

    initial begin
        int err_before;
        res         = 1'b0;
        wr_en       = 1'b0;
        addr        = '0;
        short_wr_en = 1'b0;
        short_addr  = '0;
        ro_expected = 1'b0;
        timed_out   = 1'b0;
        error_cnt   = 0;
        tests_run   = 0;
        tests_failed = 0;
        scan_pos    = 0;
        valid_seen  = 0;
        for (int i = 0; i < HIST_DEPTH; i++) begin
            model_cnt[i] = 0;
            snap_cnt[i]  = 0;
            seen_cnt[i]  = 0;
        end
        repeat (2) @(posedge clk);
        #1;
        res = 1'b1;
        for (int t = 1; t <= 6; t++) begin
            if (!timed_out) begin
                err_before = error_cnt;
                run_test(t);
                tests_run++;
                if (error_cnt > err_before || timed_out) begin
                    tests_failed++;
                    $display("test %0d %s failed, %0d errors", t, test_name(t),
                             error_cnt - err_before);
                end else begin
                    $display("test %0d %s passed", t, test_name(t));
                end
            end
        end
        $display("tests run %0d, tests failed %0d, check errors %0d, timeout %0d",
                 tests_run, tests_failed, error_cnt, timed_out);
        if (error_cnt == 0 && !timed_out && tests_run == 6) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
